//--- src/cornet_pkg.sv
package cornet_pkg;

   typedef logic [15:0] addr_t;
   typedef logic [7:0]  byte_t;

   // Low byte of the reset vector, high byte follows at +1.
   localparam addr_t RESET_VECTOR = 16'hFFFC;

   typedef enum logic [7:0] {
      OP_ORA_IMM  = 8'h09,
      OP_AND_IMM  = 8'h29,
      OP_JMP_ABS  = 8'h4C,
      OP_STA_ZP   = 8'h85,
      OP_DEY      = 8'h88,
      OP_STA_ABS  = 8'h8D,
      OP_STA_ABSX = 8'h9D,
      OP_LDY_IMM  = 8'hA0,
      OP_LDX_IMM  = 8'hA2,
      OP_LDA_ZP   = 8'hA5,
      OP_LDA_IMM  = 8'hA9,
      OP_LDA_ABS  = 8'hAD,
      OP_CPY_IMM  = 8'hC0,
      OP_INY      = 8'hC8,
      OP_CMP_IMM  = 8'hC9,
      OP_DEX      = 8'hCA,
      OP_BNE      = 8'hD0,
      OP_CPX_IMM  = 8'hE0,
      OP_INC_ZP   = 8'hE6,
      OP_INX      = 8'hE8,
      OP_BEQ      = 8'hF0
   } opcode_e;

   typedef enum logic [2:0] {
      MODE_IMPLIED, MODE_IMM, MODE_ZP, MODE_ABS, MODE_ABS_X, MODE_REL
   } mode_e;

   typedef enum logic [2:0] {
      ALU_PASS, ALU_AND, ALU_OR, ALU_CMP, ALU_INC, ALU_DEC
   } alu_op_e;

   // REG_M stands for the memory operand, or no register at all as a destination.
   typedef enum logic [1:0] {
      REG_A, REG_X, REG_Y, REG_M
   } reg_sel_e;

   typedef struct packed {
      logic       known;
      mode_e      mode;
      alu_op_e    alu_op;
      reg_sel_e   src;
      reg_sel_e   dst;
      logic       is_store;
      logic       is_jump;
      logic       is_branch;
      logic       branch_on_zero;
      logic       sets_z;
      logic [1:0] length;
   } decode_t;

   typedef enum logic [2:0] {
      ST_VECTOR, ST_FETCH, ST_WAIT_FETCH, ST_OPERAND,
      ST_WAIT_OPERAND, ST_ACCESS, ST_WAIT_ACCESS, ST_MODIFY_WRITE
   } seq_state_e;

   typedef enum logic [1:0] {
      BE_IDLE, BE_READ_BYTE, BE_WORD_LOW, BE_WORD_HIGH
   } bus_state_e;

   typedef enum logic [2:0] {
      BUS_NONE, BUS_FETCH, BUS_BYTE, BUS_WORD, BUS_WRITE
   } bus_kind_e;

   typedef struct packed {
      bus_kind_e kind;
      addr_t     addr;
      byte_t     wr_data;
   } bus_req_t;

   typedef struct packed {
      logic  ack;
      byte_t rd_byte;
      addr_t rd_word;
      logic  busy;
   } bus_rsp_t;

endpackage

//--- src/cornet_cpu.sv
module cornet_cpu
   import cornet_pkg::*;
(
   input  logic  clk,
   input  logic  reset_n,
   output addr_t addr,
   input  byte_t rd_data,
   output byte_t wr_data,
   output logic  wr_en,
   output logic  rd_req,
   input  logic  ready
);

   byte_t    opcode;
   decode_t  dec;
   alu_op_e  alu_op;
   byte_t    operand_a;
   byte_t    operand_b;
   byte_t    result;
   logic     zero;
   bus_req_t bus_req;
   bus_rsp_t bus_rsp;

   cpu_sequencer u_sequencer (
      .clk       (clk),
      .reset_n   (reset_n),
      .opcode    (opcode),
      .dec       (dec),
      .alu_op    (alu_op),
      .operand_a (operand_a),
      .operand_b (operand_b),
      .result    (result),
      .zero      (zero),
      .bus_req   (bus_req),
      .bus_rsp   (bus_rsp)
   );

   cpu_decoder u_decoder (
      .opcode (opcode),
      .dec    (dec)
   );

   cpu_alu u_alu (
      .alu_op    (alu_op),
      .operand_a (operand_a),
      .operand_b (operand_b),
      .result    (result),
      .zero      (zero)
   );

   bus_engine u_bus (
      .clk     (clk),
      .reset_n (reset_n),
      .bus_req (bus_req),
      .bus_rsp (bus_rsp),
      .addr    (addr),
      .rd_data (rd_data),
      .wr_data (wr_data),
      .wr_en   (wr_en),
      .rd_req  (rd_req),
      .ready   (ready)
   );

endmodule

//--- src/cpu_decoder.sv
module cpu_decoder
   import cornet_pkg::*;
(
   input  byte_t   opcode,
   output decode_t dec
);

   function automatic decode_t entry(input mode_e mode, input alu_op_e op,
                                     input reg_sel_e src, input reg_sel_e dst,
                                     input logic [1:0] length, input logic sets_z);
      decode_t d;
      d        = '0;
      d.known  = 1'b1;
      d.mode   = mode;
      d.alu_op = op;
      d.src    = src;
      d.dst    = dst;
      d.length = length;
      d.sets_z = sets_z;
      return d;
   endfunction

   always_comb
   begin
      dec        = '0;
      dec.length = 2'd1;
      case (opcode)
         OP_LDA_IMM:  dec = entry(MODE_IMM, ALU_PASS, REG_A, REG_A, 2'd2, 1'b1);
         // LDX and LDY leave Z alone.
         OP_LDX_IMM:  dec = entry(MODE_IMM, ALU_PASS, REG_X, REG_X, 2'd2, 1'b0);
         OP_LDY_IMM:  dec = entry(MODE_IMM, ALU_PASS, REG_Y, REG_Y, 2'd2, 1'b0);
         OP_LDA_ZP:   dec = entry(MODE_ZP, ALU_PASS, REG_A, REG_A, 2'd2, 1'b1);
         OP_LDA_ABS:  dec = entry(MODE_ABS, ALU_PASS, REG_A, REG_A, 2'd3, 1'b1);
         OP_STA_ZP:
         begin
            dec          = entry(MODE_ZP, ALU_PASS, REG_A, REG_M, 2'd2, 1'b0);
            dec.is_store = 1'b1;
         end
         OP_STA_ABS:
         begin
            dec          = entry(MODE_ABS, ALU_PASS, REG_A, REG_M, 2'd3, 1'b0);
            dec.is_store = 1'b1;
         end
         OP_STA_ABSX:
         begin
            dec          = entry(MODE_ABS_X, ALU_PASS, REG_A, REG_M, 2'd3, 1'b0);
            dec.is_store = 1'b1;
         end
         OP_INX:      dec = entry(MODE_IMPLIED, ALU_INC, REG_X, REG_X, 2'd1, 1'b1);
         OP_INY:      dec = entry(MODE_IMPLIED, ALU_INC, REG_Y, REG_Y, 2'd1, 1'b1);
         OP_DEX:      dec = entry(MODE_IMPLIED, ALU_DEC, REG_X, REG_X, 2'd1, 1'b1);
         OP_DEY:      dec = entry(MODE_IMPLIED, ALU_DEC, REG_Y, REG_Y, 2'd1, 1'b1);
         OP_AND_IMM:  dec = entry(MODE_IMM, ALU_AND, REG_A, REG_A, 2'd2, 1'b1);
         OP_ORA_IMM:  dec = entry(MODE_IMM, ALU_OR, REG_A, REG_A, 2'd2, 1'b1);
         // Compares only touch Z.
         OP_CMP_IMM:  dec = entry(MODE_IMM, ALU_CMP, REG_A, REG_M, 2'd2, 1'b1);
         OP_CPX_IMM:  dec = entry(MODE_IMM, ALU_CMP, REG_X, REG_M, 2'd2, 1'b1);
         OP_CPY_IMM:  dec = entry(MODE_IMM, ALU_CMP, REG_Y, REG_M, 2'd2, 1'b1);
         OP_INC_ZP:   dec = entry(MODE_ZP, ALU_INC, REG_M, REG_M, 2'd2, 1'b1);
         OP_BNE:
         begin
            dec           = entry(MODE_REL, ALU_PASS, REG_A, REG_M, 2'd2, 1'b0);
            dec.is_branch = 1'b1;
         end
         OP_BEQ:
         begin
            dec                = entry(MODE_REL, ALU_PASS, REG_A, REG_M, 2'd2, 1'b0);
            dec.is_branch      = 1'b1;
            dec.branch_on_zero = 1'b1;
         end
         OP_JMP_ABS:
         begin
            dec         = entry(MODE_ABS, ALU_PASS, REG_A, REG_M, 2'd3, 1'b0);
            dec.is_jump = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

//--- src/cpu_sequencer.sv
module cpu_sequencer
   import cornet_pkg::*;
(
   input  logic     clk,
   input  logic     reset_n,
   output byte_t    opcode,
   input  decode_t  dec,
   output alu_op_e  alu_op,
   output byte_t    operand_a,
   output byte_t    operand_b,
   input  byte_t    result,
   input  logic     zero,
   output bus_req_t bus_req,
   input  bus_rsp_t bus_rsp
);

   seq_state_e state;
   addr_t      pc;
   addr_t      ea;
   byte_t      reg_ir;
   byte_t      reg_a;
   byte_t      reg_x;
   byte_t      reg_y;
   logic       flag_z;

   addr_t      pc_seq;
   addr_t      pc_branch;
   addr_t      ea_calc;
   logic       taken;
   logic       needs_operand;
   logic       issue;
   logic       commit;

   assign opcode    = reg_ir;
   assign alu_op    = dec.alu_op;
   assign operand_b = bus_rsp.rd_byte;

   assign pc_seq        = pc + addr_t'(dec.length);
   assign pc_branch     = pc_seq + {{8{bus_rsp.rd_byte[7]}}, bus_rsp.rd_byte};
   assign taken         = (flag_z == dec.branch_on_zero);
   // An untaken branch never needs its offset byte.
   assign needs_operand = (dec.mode != MODE_IMPLIED) && (!dec.is_branch || taken);
   assign issue         = (bus_req.kind != BUS_NONE);

   // Cycle in which the ALU result of the instruction is final.
   assign commit = (state == ST_OPERAND && dec.known && dec.mode == MODE_IMPLIED) ||
                   (bus_rsp.ack && state == ST_WAIT_OPERAND && dec.mode == MODE_IMM) ||
                   (bus_rsp.ack && state == ST_WAIT_ACCESS);

   always_comb
   begin
      case (dec.src)
         REG_A:   operand_a = reg_a;
         REG_X:   operand_a = reg_x;
         REG_Y:   operand_a = reg_y;
         default: operand_a = bus_rsp.rd_byte;
      endcase
   end

   always_comb
   begin
      case (dec.mode)
         MODE_ABS:   ea_calc = bus_rsp.rd_word;
         MODE_ABS_X: ea_calc = bus_rsp.rd_word + {8'h00, reg_x};
         default:    ea_calc = {8'h00, bus_rsp.rd_byte};
      endcase
   end

   always_comb
   begin
      bus_req.kind    = BUS_NONE;
      bus_req.addr    = pc;
      bus_req.wr_data = operand_a;
      if (!bus_rsp.busy && !bus_rsp.ack)
      begin
         case (state)
            ST_VECTOR:
            begin
               bus_req.kind = BUS_WORD;
               bus_req.addr = RESET_VECTOR;
            end
            ST_FETCH:
               bus_req.kind = BUS_FETCH;
            ST_OPERAND:
               if (dec.known && needs_operand)
               begin
                  bus_req.kind = (dec.length == 2'd3) ? BUS_WORD : BUS_BYTE;
                  bus_req.addr = pc + 16'd1;
               end
            ST_ACCESS:
            begin
               bus_req.kind = dec.is_store ? BUS_WRITE : BUS_BYTE;
               bus_req.addr = ea;
            end
            ST_MODIFY_WRITE:
            begin
               bus_req.kind    = BUS_WRITE;
               bus_req.addr    = ea;
               bus_req.wr_data = result;
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state  <= ST_VECTOR;
         pc     <= '0;
         reg_a  <= '0;
         reg_x  <= '0;
         reg_y  <= '0;
         flag_z <= 1'b0;
      end
      else
      begin
         if (commit)
         begin
            case (dec.dst)
               REG_A:   reg_a <= result;
               REG_X:   reg_x <= result;
               REG_Y:   reg_y <= result;
               default: ;
            endcase
            if (dec.sets_z)
               flag_z <= zero;
         end

         case (state)
            ST_VECTOR:
               if (bus_rsp.ack)
               begin
                  pc    <= bus_rsp.rd_word;
                  state <= ST_FETCH;
               end
            ST_FETCH:
               if (issue)
                  state <= ST_WAIT_FETCH;
            ST_WAIT_FETCH:
               if (bus_rsp.ack)
               begin
                  reg_ir <= bus_rsp.rd_byte;
                  state  <= ST_OPERAND;
               end
            // Unknown opcodes stay here for good.
            ST_OPERAND:
               if (issue)
                  state <= ST_WAIT_OPERAND;
               else if (dec.known && !needs_operand)
               begin
                  pc    <= pc_seq;
                  state <= ST_FETCH;
               end
            ST_WAIT_OPERAND:
               if (bus_rsp.ack)
               begin
                  if (dec.is_branch)
                     pc <= pc_branch;
                  else if (dec.is_jump)
                     pc <= bus_rsp.rd_word;
                  else if (dec.mode == MODE_IMM)
                     pc <= pc_seq;
                  else
                     ea <= ea_calc;
                  if (dec.is_branch || dec.is_jump || dec.mode == MODE_IMM)
                     state <= ST_FETCH;
                  else
                     state <= ST_ACCESS;
               end
            ST_ACCESS:
               if (issue)
               begin
                  if (dec.is_store)
                  begin
                     pc    <= pc_seq;
                     state <= ST_FETCH;
                  end
                  else
                     state <= ST_WAIT_ACCESS;
               end
            ST_WAIT_ACCESS:
               if (bus_rsp.ack)
               begin
                  if (dec.dst == REG_M)
                     state <= ST_MODIFY_WRITE;
                  else
                  begin
                     pc    <= pc_seq;
                     state <= ST_FETCH;
                  end
               end
            ST_MODIFY_WRITE:
               if (issue)
               begin
                  pc    <= pc_seq;
                  state <= ST_FETCH;
               end
            default:
               state <= ST_VECTOR;
         endcase
      end
   end

endmodule

//--- src/cpu_alu.sv
module cpu_alu
   import cornet_pkg::*;
(
   input  alu_op_e alu_op,
   input  byte_t   operand_a,
   input  byte_t   operand_b,
   output byte_t   result,
   output logic    zero
);

   always_comb
   begin
      case (alu_op)
         ALU_PASS:
            result = operand_b;
         ALU_AND:
            result = operand_a & operand_b;
         ALU_OR:
            result = operand_a | operand_b;
         // Only the zero test of the difference is used.
         ALU_CMP:
            result = operand_a - operand_b;
         ALU_INC:
            result = operand_a + 8'd1;
         ALU_DEC:
            result = operand_a - 8'd1;
         default:
            result = operand_b;
      endcase
   end

   assign zero = (result == 8'h00);

endmodule

//--- src/bus_engine.sv
module bus_engine
   import cornet_pkg::*;
(
   input  logic     clk,
   input  logic     reset_n,
   input  bus_req_t bus_req,
   output bus_rsp_t bus_rsp,
   output addr_t    addr,
   input  byte_t    rd_data,
   output byte_t    wr_data,
   output logic     wr_en,
   output logic     rd_req,
   input  logic     ready
);

   bus_state_e state;
   logic       ack;
   byte_t      rd_byte;
   addr_t      rd_word;
   logic       done;

   // Ready is not trusted in the cycle of our own rd_req.
   assign done = ready && !rd_req;

   assign bus_rsp.ack     = ack;
   assign bus_rsp.rd_byte = rd_byte;
   assign bus_rsp.rd_word = rd_word;
   assign bus_rsp.busy    = (state != BE_IDLE);

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state  <= BE_IDLE;
         ack    <= 1'b0;
         rd_req <= 1'b0;
         wr_en  <= 1'b0;
      end
      else
      begin
         ack    <= 1'b0;
         rd_req <= 1'b0;
         wr_en  <= 1'b0;
         case (state)
            BE_IDLE:
               case (bus_req.kind)
                  BUS_FETCH, BUS_BYTE:
                  begin
                     addr   <= bus_req.addr;
                     rd_req <= 1'b1;
                     state  <= BE_READ_BYTE;
                  end
                  BUS_WORD:
                  begin
                     addr   <= bus_req.addr;
                     rd_req <= 1'b1;
                     state  <= BE_WORD_LOW;
                  end
                  BUS_WRITE:
                  begin
                     addr    <= bus_req.addr;
                     wr_data <= bus_req.wr_data;
                     wr_en   <= 1'b1;
                  end
                  default: ;
               endcase
            BE_READ_BYTE:
               if (done)
               begin
                  rd_byte <= rd_data;
                  ack     <= 1'b1;
                  state   <= BE_IDLE;
               end
            BE_WORD_LOW:
               if (done)
               begin
                  rd_word[7:0] <= rd_data;
                  addr         <= addr + 16'd1;
                  rd_req       <= 1'b1;
                  state        <= BE_WORD_HIGH;
               end
            BE_WORD_HIGH:
               if (done)
               begin
                  rd_word[15:8] <= rd_data;
                  ack           <= 1'b1;
                  state         <= BE_IDLE;
               end
            default:
               state <= BE_IDLE;
         endcase
      end
   end

endmodule

//--- sim/cornet_mem.sv
module cornet_mem
   import cornet_pkg::*;
(
   input  logic  clk,
   input  addr_t addr,
   input  byte_t wr_data,
   input  logic  wr_en,
   input  logic  rd_req,
   output logic  ready = 1'b1,
   output byte_t rd_data = 8'h00
);
   timeunit 1ns;
   timeprecision 100ps;

   byte_t       mem [0:65535];
   logic [31:0] lfsr = 32'h8490a8fd;
   logic [1:0]  wait_cnt = 2'd0;

   // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit.
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   task automatic load_byte(input addr_t a, input byte_t d);
      mem[a] = d;
   endtask

   // Each read sees 0 to 3 extra cycles of ready low.
   always @(negedge clk)
   begin
      if (wr_en)
         mem[addr] = wr_data;
      if (rd_req)
      begin
         wait_cnt = 2'(rand_bits(2));
         if (wait_cnt == 2'd0)
         begin
            ready   <= 1'b1;
            rd_data <= mem[addr];
         end
         else
            ready <= 1'b0;
      end
      else if (!ready)
      begin
         wait_cnt = wait_cnt - 2'd1;
         if (wait_cnt == 2'd0)
         begin
            ready   <= 1'b1;
            rd_data <= mem[addr];
         end
      end
   end

endmodule

//--- sim/cornet_tb.sv
module cornet_tb
   import cornet_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   typedef struct packed {
      logic  is_wr;
      addr_t addr;
      byte_t data;
   } bus_ev_t;

   logic  clk;
   logic  reset_n;
   addr_t addr;
   byte_t rd_data;
   byte_t wr_data;
   logic  wr_en;
   logic  rd_req;
   logic  ready;

   byte_t   model_mem [0:65535];
   bit      is_start [0:65535];
   addr_t   m_pc;
   byte_t   m_a;
   byte_t   m_x;
   byte_t   m_y;
   logic    m_z;
   bus_ev_t exp_q [$];
   byte_t   kept_ops [21] = '{8'h09, 8'h29, 8'h4C, 8'h85, 8'h88, 8'h8D, 8'h9D, 8'hA0, 8'hA2,
                              8'hA5, 8'hA9, 8'hAD, 8'hC0, 8'hC8, 8'hC9, 8'hCA, 8'hD0, 8'hE0,
                              8'hE6, 8'hE8, 8'hF0};
   int      budget;
   int      checks;
   int      errors;
   int      reset_err;
   int      flow_err;
   int      store_err;
   int      inc_err;
   int      n_instr;
   int      n_writes;
   int      n_inc;
   logic    stalled;

   cornet_cpu u_dut (
      .clk     (clk),
      .reset_n (reset_n),
      .addr    (addr),
      .rd_data (rd_data),
      .wr_data (wr_data),
      .wr_en   (wr_en),
      .rd_req  (rd_req),
      .ready   (ready)
   );

   cornet_mem u_mem (
      .clk     (clk),
      .addr    (addr),
      .wr_data (wr_data),
      .wr_en   (wr_en),
      .rd_req  (rd_req),
      .ready   (ready),
      .rd_data (rd_data)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic int op_length(input byte_t op);
      case (op)
         8'h88, 8'hC8, 8'hCA, 8'hE8: return 1;
         8'h4C, 8'h8D, 8'h9D, 8'hAD: return 3;
         default:                    return 2;
      endcase
   endfunction

   // Branch and jump targets always land on an instruction start.
   task automatic fill_operands(input addr_t p);
      byte_t op;
      addr_t t;
      byte_t off;
      op = model_mem[p];
      case (op)
         8'h4C:
         begin
            t = 16'h0200;
            for (int k = 0; k < 64; k++)
            begin
               t = addr_t'(u_mem.rand_bits(15));
               if (t >= 16'h0200 && is_start[t])
                  break;
               t = 16'h0200;
            end
            model_mem[p + 16'd1] = t[7:0];
            model_mem[p + 16'd2] = t[15:8];
         end
         8'hD0, 8'hF0:
         begin
            off = 8'h00;
            for (int k = 0; k < 64; k++)
            begin
               off = byte_t'(u_mem.rand_bits(8));
               t   = p + 16'd2 + {{8{off[7]}}, off};
               if (t >= 16'h0200 && t < 16'h8000 && is_start[t])
                  break;
               off = 8'h00;
            end
            model_mem[p + 16'd1] = off;
         end
         8'h8D, 8'h9D:
         begin
            // Stores stay in 8000-FEFF, away from code.
            if (op == 8'h8D)
               t = 16'h8000 + addr_t'(u_mem.rand_bits(15) % 32'h7F00);
            else
               t = 16'h8000 + addr_t'(u_mem.rand_bits(15) % 32'h7E01);
            model_mem[p + 16'd1] = t[7:0];
            model_mem[p + 16'd2] = t[15:8];
         end
         8'hAD:
         begin
            t = addr_t'(u_mem.rand_bits(16));
            model_mem[p + 16'd1] = t[7:0];
            model_mem[p + 16'd2] = t[15:8];
         end
         default:
            if (op_length(op) == 2)
               model_mem[p + 16'd1] = byte_t'(u_mem.rand_bits(8));
      endcase
   endtask

   task automatic build_image;
      addr_t p;
      addr_t end_p;
      byte_t op;
      for (int i = 0; i < 65536; i++)
      begin
         model_mem[i] = byte_t'(u_mem.rand_bits(8));
         is_start[i]  = 1'b0;
      end
      p = 16'h0200;
      while (p < 16'h7FF0)
      begin
         op           = kept_ops[u_mem.rand_bits(5) % 21];
         is_start[p]  = 1'b1;
         model_mem[p] = op;
         p            = p + addr_t'(op_length(op));
      end
      end_p           = p;
      is_start[end_p] = 1'b1;
      for (int i = 16'h0200; i < end_p; i++)
         if (is_start[i])
            fill_operands(addr_t'(i));
      model_mem[end_p]         = 8'h4C;
      model_mem[end_p + 16'd1] = 8'h00;
      model_mem[end_p + 16'd2] = 8'h02;
      model_mem[16'hFFFC]      = 8'h00;
      model_mem[16'hFFFD]      = 8'h02;
      for (int i = 0; i < 65536; i++)
         u_mem.load_byte(addr_t'(i), model_mem[i]);
   endtask

   task automatic push_read(input addr_t a);
      exp_q.push_back({1'b0, a, 8'h00});
   endtask

   task automatic push_write(input addr_t a, input byte_t d);
      exp_q.push_back({1'b1, a, d});
      model_mem[a] = d;
   endtask

   // One instruction of the reference model, with the bus traffic it implies.
   task automatic step_model;
      byte_t op;
      byte_t v;
      addr_t pc1;
      addr_t w;
      byte_t old;
      logic  taken;
      op    = model_mem[m_pc];
      pc1   = m_pc + 16'd1;
      v     = model_mem[pc1];
      w     = {model_mem[m_pc + 16'd2], v};
      taken = 1'b0;
      push_read(m_pc);
      if (op_length(op) == 2 && op != 8'hD0 && op != 8'hF0)
         push_read(pc1);
      if (op_length(op) == 3)
      begin
         push_read(pc1);
         push_read(pc1 + 16'd1);
      end
      case (op)
         8'hA9: m_a = v;
         8'hA2: m_x = v;
         8'hA0: m_y = v;
         8'h29: m_a = m_a & v;
         8'h09: m_a = m_a | v;
         8'hE8: m_x = m_x + 8'd1;
         8'hC8: m_y = m_y + 8'd1;
         8'hCA: m_x = m_x - 8'd1;
         8'h88: m_y = m_y - 8'd1;
         8'hC9: m_z = (m_a == v);
         8'hE0: m_z = (m_x == v);
         8'hC0: m_z = (m_y == v);
         8'hA5:
         begin
            push_read({8'h00, v});
            m_a = model_mem[{8'h00, v}];
         end
         8'hAD:
         begin
            push_read(w);
            m_a = model_mem[w];
         end
         8'h85: push_write({8'h00, v}, m_a);
         8'h8D: push_write(w, m_a);
         8'h9D: push_write(w + {8'h00, m_x}, m_a);
         8'hE6:
         begin
            push_read({8'h00, v});
            old = model_mem[{8'h00, v}];
            push_write({8'h00, v}, old + 8'd1);
            m_z = ((old + 8'd1) == 8'h00);
         end
         8'hD0, 8'hF0:
         begin
            taken = (op == 8'hF0) ? m_z : !m_z;
            if (taken)
               push_read(pc1);
         end
         default: ;
      endcase
      case (op)
         8'hA9, 8'h29, 8'h09, 8'hA5, 8'hAD: m_z = (m_a == 8'h00);
         8'hE8, 8'hCA:                      m_z = (m_x == 8'h00);
         8'hC8, 8'h88:                      m_z = (m_y == 8'h00);
         default: ;
      endcase
      if (op == 8'h4C)
         m_pc = w;
      else if (taken)
         m_pc = m_pc + 16'd2 + {{8{v[7]}}, v};
      else
         m_pc = m_pc + addr_t'(op_length(op));
   endtask

   task automatic wait_bus(output bus_ev_t ev, output logic ok);
      ok = 1'b0;
      ev = '0;
      while (budget > 0 && !ok)
      begin
         @(negedge clk);
         budget = budget - 1;
         if (rd_req)
         begin
            ev = {1'b0, addr, 8'h00};
            ok = 1'b1;
         end
         else if (wr_en)
         begin
            ev = {1'b1, addr, wr_data};
            ok = 1'b1;
         end
      end
   endtask

   // Returns 1 on a mismatch, after printing it.
   function automatic int compare_event(input bus_ev_t exp, input bus_ev_t got);
      checks = checks + 1;
      if (got.is_wr != exp.is_wr)
      begin
         $display("error at %0t: wr_en expected %0b got %0b", $time, exp.is_wr, got.is_wr);
         return 1;
      end
      if (got.addr != exp.addr)
      begin
         $display("error at %0t: addr expected %h got %h", $time, exp.addr, got.addr);
         return 1;
      end
      if (exp.is_wr && got.data != exp.data)
      begin
         $display("error at %0t: wr_data expected %h got %h", $time, exp.data, got.data);
         return 1;
      end
      return 0;
   endfunction

   initial
   begin
      bus_ev_t exp_ev;
      bus_ev_t got_ev;
      logic    ok;
      byte_t   cur_op;
      int      bad;
      reset_n   = 1'b0;
      checks    = 0;
      reset_err = 0;
      flow_err  = 0;
      store_err = 0;
      inc_err   = 0;
      n_instr   = 0;
      n_writes  = 0;
      n_inc     = 0;
      stalled   = 1'b0;
      m_a       = 8'h00;
      m_x       = 8'h00;
      m_y       = 8'h00;
      m_z       = 1'b0;
      build_image;
      repeat (4)
      begin
         @(negedge clk);
         checks = checks + 1;
         if (rd_req || wr_en)
         begin
            $display("error at %0t: rd_req/wr_en expected 0/0 got %0b/%0b", $time, rd_req,
                     wr_en);
            reset_err = reset_err + 1;
         end
      end
      reset_n = 1'b1;
      budget  = 200;
      for (int i = 0; i < 2 && !stalled; i++)
      begin
         wait_bus(got_ev, ok);
         if (!ok)
         begin
            $display("CPU stalled: no reset vector read within 200 cycles");
            stalled = 1'b1;
         end
         else
            reset_err = reset_err + compare_event({1'b0, RESET_VECTOR + addr_t'(i), 8'h00},
                                                  got_ev);
      end
      $display("reset: %0d errors", reset_err);
      m_pc = {model_mem[16'hFFFD], model_mem[16'hFFFC]};
      while (n_instr < 2000 && !stalled)
      begin
         cur_op = model_mem[m_pc];
         step_model;
         budget = 200;
         while (exp_q.size() > 0 && !stalled)
         begin
            exp_ev = exp_q.pop_front();
            wait_bus(got_ev, ok);
            if (!ok)
            begin
               $display("CPU stalled: no bus activity within 200 cycles, model pc %h", m_pc);
               stalled = 1'b1;
            end
            else
            begin
               bad = compare_event(exp_ev, got_ev);
               if (cur_op == 8'hE6)
                  inc_err = inc_err + bad;
               else if (exp_ev.is_wr)
                  store_err = store_err + bad;
               else
                  flow_err = flow_err + bad;
               if (exp_ev.is_wr)
                  n_writes = n_writes + 1;
            end
         end
         if (cur_op == 8'hE6)
            n_inc = n_inc + 1;
         n_instr = n_instr + 1;
      end
      $display("program flow: %0d instructions, %0d errors", n_instr, flow_err);
      $display("stores: %0d writes, %0d errors", n_writes, store_err);
      $display("inc: %0d instructions, %0d errors", n_inc, inc_err);
      $display("back-pressure: %s", stalled ? "CPU stalled" : "no stall");
      errors = reset_err + flow_err + store_err + inc_err;
      $display("checks %0d, errors %0d", checks, errors);
      if (stalled || errors != 0)
         $display("=== FAIL ===");
      else
         $display("=== PASS ===");
      $finish;
   end

endmodule

//--- cornet.f
src/cornet_pkg.sv
src/cornet_cpu.sv
src/cpu_decoder.sv
src/cpu_sequencer.sv
src/cpu_alu.sv
src/bus_engine.sv
sim/cornet_mem.sv
sim/cornet_tb.sv

//--- Makefile
SOURCES := $(wildcard src/*.sv) $(wildcard sim/*.sv)

.PHONY: all run clean

all: obj_dir/Vcornet_tb

obj_dir/Vcornet_tb: cornet.f $(SOURCES)
	verilator --binary --timing -Wno-fatal -f cornet.f --top-module cornet_tb

run: obj_dir/Vcornet_tb
	./obj_dir/Vcornet_tb > sim.log 2>&1; cat sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
